//--- rtl/axi_responder_config.svh
// Width macros for the AXI4 burst responder, included by packages, RTL and testbench
`ifndef AXI_RESPONDER_CONFIG_SVH
`define AXI_RESPONDER_CONFIG_SVH

//////////////////////////////
// Channel field widths
//////////////////////////////

// Transaction ID on AW, B, AR and R
`define AXI_ID_W 4

// Burst length field, beats minus one
`define AXI_LEN_W 8

// Read data bus
`define AXI_DATA_W 32

//////////////////////////////
// Derived widths
//////////////////////////////

// Longest burst holds 2**AXI_LEN_W beats
`define AXI_MAX_BEATS (1 << `AXI_LEN_W)

`endif

//--- rtl/axi_chan_pkg.sv
// Packed AXI4 channel payloads shared by the responder RTL and its testbench
`default_nettype none

`include "axi_responder_config.svh"

package axi_chan_pkg;

   //////////////////////////////
   // Write side
   //////////////////////////////

   // Write address, only the ID survives
   typedef struct packed {
      logic [`AXI_ID_W-1:0] id;
   } axi_aw_t;

   // Write response, OKAY implied
   typedef struct packed {
      logic [`AXI_ID_W-1:0] id;
   } axi_b_t;

   //////////////////////////////
   // Read side
   //////////////////////////////

   // Read address, ID plus burst length
   // Length follows AXI encoding, beats minus one
   typedef struct packed {
      logic [`AXI_ID_W-1:0]  id;
      logic [`AXI_LEN_W-1:0] len;
   } axi_ar_t;

   // One read beat
   // Data carries the beat index within the burst
   typedef struct packed {
      logic [`AXI_ID_W-1:0]   id;
      logic [`AXI_DATA_W-1:0] data;
      logic                   last;
   } axi_r_t;

endpackage

`default_nettype wire

//--- rtl/resp_ctrl_pkg.sv
// Control types for the read burst FSM and its beat counter
`default_nettype none

`include "axi_responder_config.svh"

package resp_ctrl_pkg;

   //////////////////////////////
   // Read engine
   //////////////////////////////

   // Idle waits for an AR entry
   // Burst drives R until the last beat leaves
   typedef enum logic {
      RD_IDLE  = 1'b0,
      RD_BURST = 1'b1
   } rd_state_e;

   // Beat index, same width as arlen
   typedef logic [`AXI_LEN_W-1:0] beat_idx_t;

endpackage

`default_nettype wire

//--- rtl/axi_chan_reg.sv
// One-entry valid/ready holding register, instantiated per channel payload type
`default_nettype none
`timescale 1ns/100ps

module axi_chan_reg #(
   parameter type payload_t = logic
) (
   input  logic     aclk,
   input  logic     rst_n,
   // Upstream side
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   // Downstream side
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   // Entry occupied
   logic     full;
   // Held payload
   payload_t data_q;

   //////////////////////////////
   // Handshake
   //////////////////////////////

   // Room when empty, or when the entry leaves this cycle
   assign in_ready  = !full || out_ready;
   assign out_valid = full;
   assign out_data  = data_q;

   //////////////////////////////
   // Storage
   //////////////////////////////

   // Occupancy follows the upstream valid whenever room exists
   always_ff @(posedge aclk)
   begin
      if (!rst_n)
         full <= 1'b0;
      else if (in_ready)
         full <= in_valid;
   end

   // Payload captured only on a real transfer
   always_ff @(posedge aclk)
   begin
      if (in_valid && in_ready)
         data_q <= in_data;
   end

endmodule

`default_nettype wire

//--- rtl/beat_counter.sv
// Loadable read beat counter, gives the current beat index and the final-beat flag
`default_nettype none
`timescale 1ns/100ps

module beat_counter import resp_ctrl_pkg::*; (
   input  logic      aclk,
   input  logic      rst_n,
   // Start of burst
   input  logic      load,
   input  beat_idx_t len,
   // Advance one beat
   input  logic      step,
   output beat_idx_t idx,
   output logic      last
);

   // Current index and burst length
   beat_idx_t idx_q;
   beat_idx_t len_q;

   //////////////////////////////
   // Counter
   //////////////////////////////

   // Load wins over step
   always_ff @(posedge aclk)
   begin
      if (!rst_n)
      begin
         idx_q <= '0;
         len_q <= '0;
      end
      else if (load)
      begin
         idx_q <= '0;
         len_q <= len;
      end
      else if (step)
         idx_q <= idx_q + 1'b1;
   end

   // Final beat once index reaches arlen
   assign idx  = idx_q;
   assign last = (idx_q == len_q);

endmodule

`default_nettype wire

//--- rtl/burst_read_fsm.sv
// Read engine FSM, pops read addresses and steps the beat counter to emit R bursts
`default_nettype none
`timescale 1ns/100ps

`include "axi_responder_config.svh"

module burst_read_fsm import axi_chan_pkg::*, resp_ctrl_pkg::*; (
   input  logic    aclk,
   input  logic    rst_n,
   // Held read address
   input  logic    ar_valid,
   output logic    ar_ready,
   input  axi_ar_t ar_data,
   // R channel
   output logic    rvalid,
   input  logic    rready,
   output axi_r_t  r_data
);

   rd_state_e state;
   rd_state_e state_nxt;

   // ID of the burst in flight
   logic [`AXI_ID_W-1:0] rid_q;

   // Counter controls
   logic      ar_pop;
   logic      beat_step;
   beat_idx_t beat_idx;
   logic      beat_last;

   //////////////////////////////
   // Control
   //////////////////////////////

   // Only take a new address between bursts
   assign ar_ready  = (state == RD_IDLE);
   assign ar_pop    = ar_valid && ar_ready;
   assign rvalid    = (state == RD_BURST);
   // One step per R transfer
   assign beat_step = rvalid && rready;

   always_comb
   begin
      state_nxt = state;
      case (state)
         RD_IDLE:
            if (ar_valid)
               state_nxt = RD_BURST;
         RD_BURST:
            // Last beat accepted, burst done
            if (beat_step && beat_last)
               state_nxt = RD_IDLE;
         default:
            state_nxt = RD_IDLE;
      endcase
   end

   always_ff @(posedge aclk)
   begin
      if (!rst_n)
         state <= RD_IDLE;
      else
         state <= state_nxt;
   end

   // ID latched with the pop
   always_ff @(posedge aclk)
   begin
      if (ar_pop)
         rid_q <= ar_data.id;
   end

   //////////////////////////////
   // Beat index
   //////////////////////////////

   beat_counter u_beat_counter (
      .aclk  (aclk),
      .rst_n (rst_n),
      .load  (ar_pop),
      .len   (ar_data.len),
      .step  (beat_step),
      .idx   (beat_idx),
      .last  (beat_last)
   );

   // Beat data is the zero-extended index
   assign r_data.id   = rid_q;
   assign r_data.data = {{(`AXI_DATA_W - `AXI_LEN_W){1'b0}}, beat_idx};
   assign r_data.last = beat_last;

endmodule

`default_nettype wire

//--- rtl/write_resp_join.sv
// Write response join, pairs held write IDs with wlast beats and pushes B responses
`default_nettype none
`timescale 1ns/100ps

module write_resp_join import axi_chan_pkg::*; (
   input  logic    aclk,
   input  logic    rst_n,
   // Held write address
   input  logic    aw_valid,
   output logic    aw_ready,
   input  axi_aw_t aw_data,
   // W channel, data itself discarded
   input  logic    wvalid,
   output logic    wready,
   input  logic    wlast,
   // Push into the B register
   output logic    b_valid,
   input  logic    b_ready,
   output axi_b_t  b_data
);

   // A wlast beat arrived and waits for its address
   logic wlast_pend;
   logic w_done;
   logic pair;

   //////////////////////////////
   // W side
   //////////////////////////////

   // Stall W until the pending burst is paired
   assign wready = !wlast_pend;
   // Beats without wlast are just consumed
   assign w_done = wvalid && wready && wlast;

   //////////////////////////////
   // Pairing
   //////////////////////////////

   // Pop AW and push B in the same cycle
   assign aw_ready = wlast_pend && b_ready;
   assign b_valid  = aw_valid && wlast_pend;
   assign pair     = aw_valid && aw_ready;

   // Response echoes the write ID
   assign b_data.id = aw_data.id;

   // Set and clear never overlap, wready is low while pending
   always_ff @(posedge aclk)
   begin
      if (!rst_n)
         wlast_pend <= 1'b0;
      else if (w_done)
         wlast_pend <= 1'b1;
      else if (pair)
         wlast_pend <= 1'b0;
   end

endmodule

`default_nettype wire

//--- rtl/axi4_burst_responder.sv
// AXI4 burst responder top, wires bus ports to channel registers, write join and read FSM
`default_nettype none
`timescale 1ns/100ps

`include "axi_responder_config.svh"

module axi4_burst_responder import axi_chan_pkg::*; (
   input  logic                   aclk,
   input  logic                   rst_n,
   // Write address
   input  logic                   awvalid,
   output logic                   awready,
   input  logic [`AXI_ID_W-1:0]   awid,
   // Write data
   input  logic                   wvalid,
   output logic                   wready,
   input  logic                   wlast,
   // Write response
   output logic                   bvalid,
   input  logic                   bready,
   output logic [`AXI_ID_W-1:0]   bid,
   // Read address
   input  logic                   arvalid,
   output logic                   arready,
   input  logic [`AXI_ID_W-1:0]   arid,
   input  logic [`AXI_LEN_W-1:0]  arlen,
   // Read data
   output logic                   rvalid,
   input  logic                   rready,
   output logic [`AXI_ID_W-1:0]   rid,
   output logic [`AXI_DATA_W-1:0] rdata,
   output logic                   rlast
);

   // Port payloads
   axi_aw_t aw_in;
   axi_ar_t ar_in;
   axi_b_t  b_out;
   axi_r_t  r_out;

   // Held entries toward the engines
   logic    aw_q_valid;
   logic    aw_q_ready;
   axi_aw_t aw_q;
   logic    ar_q_valid;
   logic    ar_q_ready;
   axi_ar_t ar_q;

   // Join to B register
   logic    b_push_valid;
   logic    b_push_ready;
   axi_b_t  b_push;

   //////////////////////////////
   // Packing
   //////////////////////////////

   assign aw_in.id  = awid;
   assign ar_in.id  = arid;
   assign ar_in.len = arlen;
   assign bid       = b_out.id;
   assign rid       = r_out.id;
   assign rdata     = r_out.data;
   assign rlast     = r_out.last;

   //////////////////////////////
   // Write path
   //////////////////////////////

   axi_chan_reg #(.payload_t(axi_aw_t)) u_aw_reg (
      .aclk      (aclk),
      .rst_n     (rst_n),
      .in_valid  (awvalid),
      .in_ready  (awready),
      .in_data   (aw_in),
      .out_valid (aw_q_valid),
      .out_ready (aw_q_ready),
      .out_data  (aw_q)
   );

   write_resp_join u_write_resp_join (
      .aclk     (aclk),
      .rst_n    (rst_n),
      .aw_valid (aw_q_valid),
      .aw_ready (aw_q_ready),
      .aw_data  (aw_q),
      .wvalid   (wvalid),
      .wready   (wready),
      .wlast    (wlast),
      .b_valid  (b_push_valid),
      .b_ready  (b_push_ready),
      .b_data   (b_push)
   );

   // B drives the bus from a register
   axi_chan_reg #(.payload_t(axi_b_t)) u_b_reg (
      .aclk      (aclk),
      .rst_n     (rst_n),
      .in_valid  (b_push_valid),
      .in_ready  (b_push_ready),
      .in_data   (b_push),
      .out_valid (bvalid),
      .out_ready (bready),
      .out_data  (b_out)
   );

   //////////////////////////////
   // Read path
   //////////////////////////////

   axi_chan_reg #(.payload_t(axi_ar_t)) u_ar_reg (
      .aclk      (aclk),
      .rst_n     (rst_n),
      .in_valid  (arvalid),
      .in_ready  (arready),
      .in_data   (ar_in),
      .out_valid (ar_q_valid),
      .out_ready (ar_q_ready),
      .out_data  (ar_q)
   );

   burst_read_fsm u_burst_read_fsm (
      .aclk     (aclk),
      .rst_n    (rst_n),
      .ar_valid (ar_q_valid),
      .ar_ready (ar_q_ready),
      .ar_data  (ar_q),
      .rvalid   (rvalid),
      .rready   (rready),
      .r_data   (r_out)
   );

endmodule

`default_nettype wire

//--- tests/axi4_burst_responder_assertions.sv
// Concurrent protocol checks on the responder ports, bound into every responder instance
`default_nettype none
`timescale 1ns/100ps

`include "axi_responder_config.svh"

module axi4_burst_responder_assertions (
   input logic                   aclk,
   input logic                   rst_n,
   input logic                   bvalid,
   input logic                   bready,
   input logic [`AXI_ID_W-1:0]   bid,
   input logic                   rvalid,
   input logic                   rready,
   input logic [`AXI_ID_W-1:0]   rid,
   input logic [`AXI_DATA_W-1:0] rdata,
   input logic                   rlast
);

   // Failed checks so far, watched by the testbench
   int fail_count;

   initial fail_count = 0;

   //////////////////////////////
   // Stalled responses hold
   //////////////////////////////

   a_b_hold: assert property (@(posedge aclk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid && $stable(bid))
   else
   begin
      $error("B response dropped or changed while bready was low");
      fail_count = fail_count + 1;
   end

   a_r_hold: assert property (@(posedge aclk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid && $stable(rid) && $stable(rdata) && $stable(rlast))
   else
   begin
      $error("R beat dropped or changed while rready was low");
      fail_count = fail_count + 1;
   end

   //////////////////////////////
   // Burst continuity
   //////////////////////////////

   // A non-final beat is followed by the next index of the same burst
   a_r_next: assert property (@(posedge aclk) disable iff (!rst_n)
      rvalid && rready && !rlast |=>
         rvalid && (rid == $past(rid)) && (rdata == $past(rdata) + 32'd1))
   else
   begin
      $error("R burst skipped a beat or changed its ID");
      fail_count = fail_count + 1;
   end

endmodule

bind axi4_burst_responder axi4_burst_responder_assertions u_responder_assertions (.*);

`default_nettype wire

//--- tests/tb_axi4_burst_responder.sv
// Trace-driven testbench for the AXI4 burst responder, run from the project root by the Makefile
`default_nettype none
`timescale 1ns/100ps

`include "axi_responder_config.svh"

module tb_axi4_burst_responder import axi_chan_pkg::*; ();

   localparam int    TIMEOUT_CYCLES = 2000;
   localparam int    TRACE_WORDS    = 192;
   localparam string TRACE_FILE     = "tests/responder_trace.txt";
   // Channel selectors for the ready wait
   localparam int    CH_AW = 0;
   localparam int    CH_W  = 1;
   localparam int    CH_AR = 2;

   logic                   aclk;
   logic                   rst_n;
   logic                   awvalid;
   logic                   awready;
   logic [`AXI_ID_W-1:0]   awid;
   logic                   wvalid;
   logic                   wready;
   logic                   wlast;
   logic                   bvalid;
   logic                   bready;
   logic [`AXI_ID_W-1:0]   bid;
   logic                   arvalid;
   logic                   arready;
   logic [`AXI_ID_W-1:0]   arid;
   logic [`AXI_LEN_W-1:0]  arlen;
   logic                   rvalid;
   logic                   rready;
   logic [`AXI_ID_W-1:0]   rid;
   logic [`AXI_DATA_W-1:0] rdata;
   logic                   rlast;

   // Raw trace words, three per transaction
   logic [7:0] trace_mem [0:TRACE_WORDS-1];
   int         n_words;
   // Expected responses in arrival order
   logic [`AXI_ID_W-1:0] exp_bid [$];
   axi_r_t               exp_r [$];

   axi4_burst_responder u_axi4_burst_responder (
      .aclk (aclk), .rst_n (rst_n),
      .awvalid (awvalid), .awready (awready), .awid (awid),
      .wvalid (wvalid), .wready (wready), .wlast (wlast),
      .bvalid (bvalid), .bready (bready), .bid (bid),
      .arvalid (arvalid), .arready (arready), .arid (arid), .arlen (arlen),
      .rvalid (rvalid), .rready (rready), .rid (rid), .rdata (rdata), .rlast (rlast)
   );

   always #5 aclk = ~aclk;

   //////////////////////////////
   // Reporting
   //////////////////////////////

   task automatic stop_run(input string reason);
      $display("%s", reason);
      $display("Test FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (actual !== expected)
         stop_run($sformatf("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h",
                            $time, name, expected, actual));
   endtask

   // Bound assertions count their failures
   always @(negedge aclk)
   begin
      if (u_axi4_burst_responder.u_responder_assertions.fail_count != 0)
         stop_run("A protocol assertion on the DUT ports failed");
   end

   //////////////////////////////
   // Trace and expected values
   //////////////////////////////

   task automatic load_trace();
      int     pos;
      int     count;
      axi_r_t beat;
      $readmemh(TRACE_FILE, trace_mem);
      pos = 0;
      while (pos < TRACE_WORDS && trace_mem[pos] != 8'h00)
      begin
         count = int'(trace_mem[pos+2]);
         if (trace_mem[pos] == 8'h01)
            exp_bid.push_back(trace_mem[pos+1][`AXI_ID_W-1:0]);
         else if (trace_mem[pos] == 8'h02)
         begin
            // arlen+1 beats, data counts up from zero
            for (int k = 0; k <= count; k++)
            begin
               beat.id   = trace_mem[pos+1][`AXI_ID_W-1:0];
               beat.data = 32'(k);
               beat.last = (k == count);
               exp_r.push_back(beat);
            end
         end
         else
            stop_run("The trace holds an unknown transaction kind");
         pos += 3;
      end
      n_words = pos;
   endtask

   //////////////////////////////
   // Request drivers
   //////////////////////////////

   function automatic logic ready_of(input int ch);
      case (ch)
         CH_AW:   return awready;
         CH_W:    return wready;
         default: return arready;
      endcase
   endfunction

   // Enters and leaves on a falling edge
   task automatic wait_ready(input int ch, input string what);
      int waited;
      waited = 0;
      @(posedge aclk);
      while (!ready_of(ch))
      begin
         if (waited == TIMEOUT_CYCLES)
            stop_run($sformatf("Timeout waiting for %s", what));
         waited++;
         @(posedge aclk);
      end
      @(negedge aclk);
   endtask

   task automatic send_aw(input logic [`AXI_ID_W-1:0] id);
      awvalid = 1'b1;
      awid    = id;
      wait_ready(CH_AW, "awready on a write address");
      awvalid = 1'b0;
   endtask

   task automatic send_w(input int beats);
      for (int i = 0; i < beats; i++)
      begin
         wvalid = 1'b1;
         wlast  = (i == beats - 1);
         wait_ready(CH_W, "wready on a write data beat");
      end
      wvalid = 1'b0;
      wlast  = 1'b0;
   endtask

   task automatic send_ar(input logic [`AXI_ID_W-1:0] id, input logic [`AXI_LEN_W-1:0] len);
      arvalid = 1'b1;
      arid    = id;
      arlen   = len;
      wait_ready(CH_AR, "arready on a read address");
      arvalid = 1'b0;
   endtask

   // Reads do not wait for R, so the next AR lands during a burst
   task automatic drive_requests();
      int pos;
      pos = 0;
      @(negedge aclk);
      while (pos < n_words)
      begin
         if (trace_mem[pos] == 8'h01)
            fork
               send_aw(trace_mem[pos+1][`AXI_ID_W-1:0]);
               send_w(int'(trace_mem[pos+2]));
            join
         else
            send_ar(trace_mem[pos+1][`AXI_ID_W-1:0], trace_mem[pos+2]);
         pos += 3;
      end
   endtask

   //////////////////////////////
   // Response collectors
   //////////////////////////////

   task automatic collect_b();
      int                   waited;
      logic                 held;
      logic [`AXI_ID_W-1:0] held_bid;
      logic [`AXI_ID_W-1:0] want_bid;
      waited = 0;
      held   = 1'b0;
      while (exp_bid.size() != 0)
      begin
         @(negedge aclk);
         bready = ($urandom % 4) != 0;
         @(posedge aclk);
         // Stalled response still there
         if (held)
         begin
            compare_value("bvalid", 32'(1'b1), 32'(bvalid));
            compare_value("bid", 32'(held_bid), 32'(bid));
         end
         held = 1'b0;
         if (bvalid && bready)
         begin
            want_bid = exp_bid.pop_front();
            compare_value("bid", 32'(want_bid), 32'(bid));
            waited = 0;
         end
         else if (bvalid)
         begin
            held     = 1'b1;
            held_bid = bid;
            waited   = 0;
         end
         else
         begin
            if (waited == TIMEOUT_CYCLES)
               stop_run("Timeout waiting for bvalid on a write response");
            waited++;
         end
      end
      @(negedge aclk);
      bready = 1'b0;
   endtask

   task automatic collect_r();
      int     waited;
      logic   held;
      axi_r_t held_beat;
      axi_r_t want;
      waited = 0;
      held   = 1'b0;
      while (exp_r.size() != 0)
      begin
         @(negedge aclk);
         rready = ($urandom % 4) != 0;
         @(posedge aclk);
         if (held)
         begin
            compare_value("rvalid", 32'(1'b1), 32'(rvalid));
            compare_value("rid", 32'(held_beat.id), 32'(rid));
            compare_value("rdata", held_beat.data, rdata);
            compare_value("rlast", 32'(held_beat.last), 32'(rlast));
         end
         held = 1'b0;
         if (rvalid && rready)
         begin
            want = exp_r.pop_front();
            compare_value("rid", 32'(want.id), 32'(rid));
            compare_value("rdata", want.data, rdata);
            compare_value("rlast", 32'(want.last), 32'(rlast));
            waited = 0;
         end
         else if (rvalid)
         begin
            held           = 1'b1;
            held_beat.id   = rid;
            held_beat.data = rdata;
            held_beat.last = rlast;
            waited         = 0;
         end
         else
         begin
            if (waited == TIMEOUT_CYCLES)
               stop_run("Timeout waiting for rvalid on a read beat");
            waited++;
         end
      end
      @(negedge aclk);
      rready = 1'b0;
   endtask

   // No response without a request
   task automatic check_idle(input int cycles);
      repeat (cycles)
      begin
         @(posedge aclk);
         compare_value("bvalid", 32'(1'b0), 32'(bvalid));
         compare_value("rvalid", 32'(1'b0), 32'(rvalid));
      end
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial
   begin
      void'($urandom(22114));
      aclk    = 1'b0;
      rst_n   = 1'b0;
      awvalid = 1'b0;
      awid    = '0;
      wvalid  = 1'b0;
      wlast   = 1'b0;
      bready  = 1'b0;
      arvalid = 1'b0;
      arid    = '0;
      arlen   = '0;
      rready  = 1'b0;
      load_trace();
      repeat (4) @(posedge aclk);
      @(negedge aclk);
      rst_n = 1'b1;
      @(posedge aclk);
      // Empty registers take requests at once
      compare_value("wready", 32'(1'b1), 32'(wready));
      compare_value("awready", 32'(1'b1), 32'(awready));
      compare_value("arready", 32'(1'b1), 32'(arready));
      check_idle(5);
      fork
         drive_requests();
         collect_b();
         collect_r();
      join
      // Nothing extra after the last expected response
      check_idle(20);
      if (u_axi4_burst_responder.u_responder_assertions.fail_count == 0)
      begin
         $display("Test OK");
         $finish;
      end
      else
      begin
         $display("Test FAILED");
         $fatal(1, "protocol assertion failures");
      end
   end

endmodule

`default_nettype wire

//--- tests/responder_trace.txt
// Three hex fields per transaction: kind, ID, count
// Kind 01 is a write with count data beats, 02 a read with count as arlen, 00 ends the trace
01 3 01
01 a 04
02 5 03
02 6 00
02 7 0f
01 1 02
01 2 01
02 c 07
02 d 02
02 e 01
01 f 08
01 0 03
02 9 1f
01 8 01
02 4 04
00 0 00

//--- tb.f
+incdir+rtl
rtl/axi_chan_pkg.sv
rtl/resp_ctrl_pkg.sv
rtl/axi_chan_reg.sv
rtl/beat_counter.sv
rtl/burst_read_fsm.sv
rtl/write_resp_join.sv
rtl/axi4_burst_responder.sv
tests/axi4_burst_responder_assertions.sv
tests/tb_axi4_burst_responder.sv

//--- Makefile
# Verilator build and run for the AXI4 burst responder testbench

VERILATOR ?= verilator
TOP       ?= tb_axi4_burst_responder
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard rtl/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)
